/* hw/pdu_pkg.sv */
package pdu_pkg;

    // flit geometry
    localparam int FLIT_WIDTH  = 512;
    localparam int FLIT_BYTES  = FLIT_WIDTH / 8;
    localparam int EMPTY_WIDTH = $clog2(FLIT_BYTES);

    localparam int PDUID_WIDTH = 32;

    // header field widths
    localparam int QUEUE_WIDTH  = 32;
    localparam int ACTION_WIDTH = 8;
    localparam int PFLIT_WIDTH  = 16;
    localparam int PSIZE_WIDTH  = 16;
    localparam int PROT_WIDTH   = 32;
    localparam int TUPLE_WIDTH  = 96;

    // whatever the fields leave over in a 512-bit header
    localparam int HDR_PAD_WIDTH = FLIT_WIDTH - QUEUE_WIDTH - ACTION_WIDTH
                                 - PFLIT_WIDTH - PSIZE_WIDTH - PROT_WIDTH
                                 - TUPLE_WIDTH - PDUID_WIDTH;

    // flow identity, 96 bits
    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
    } tuple_t;

    // one record per packet
    typedef struct packed {
        logic [QUEUE_WIDTH-1:0] queue_id;
        logic [PROT_WIDTH-1:0]  prot;
        tuple_t                 tuple;
    } metadata_t;

    // header flit, written at the PDU base address
    typedef struct packed {
        logic [HDR_PAD_WIDTH-1:0] padding;
        logic [QUEUE_WIDTH-1:0]   queue_id;
        logic [ACTION_WIDTH-1:0]  action;
        logic [PFLIT_WIDTH-1:0]   pdu_flit;
        logic [PSIZE_WIDTH-1:0]   pdu_size;
        logic [PROT_WIDTH-1:0]    prot;
        tuple_t                   tuple;
        logic [PDUID_WIDTH-1:0]   pdu_id;
    } pdu_hdr_t;

    // ring buffer entry
    typedef struct packed {
        logic [FLIT_WIDTH-1:0] data;
        logic                  sop;
        logic                  eop;
    } flit_lite_t;

endpackage

/* hw/rb_mem.sv */
`timescale 1ns/1ps

module rb_mem #(
    parameter int PDU_AWIDTH = 6
) (
    input  logic                   clk,
    input  logic                   wr_en,
    input  logic [PDU_AWIDTH-1:0]  wr_addr,
    input  pdu_pkg::flit_lite_t    wr_data,
    input  logic                   rd_en,
    input  logic [PDU_AWIDTH-1:0]  rd_addr,
    output pdu_pkg::flit_lite_t    rd_flit
);

    localparam int DEPTH = 1 << PDU_AWIDTH;

    pdu_pkg::flit_lite_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, data valid the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_flit <= mem[rd_addr];
        end
    end

endmodule

/* hw/rb_ctrl.sv */
`timescale 1ns/1ps

module rb_ctrl #(
    parameter int PDU_AWIDTH    = 6,
    parameter int MAX_PDU_FLITS = 9
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   update_valid,
    input  logic [PDU_AWIDTH-1:0]  update_size,
    input  logic                   rd_en,
    output logic [PDU_AWIDTH-1:0]  base_addr,
    output logic                   base_addr_valid,
    output logic                   almost_full,
    output logic [PDU_AWIDTH-1:0]  rd_addr_mem,
    output logic                   rd_en_mem,
    output logic                   rd_valid,
    output logic [PDU_AWIDTH:0]    occupancy
);

    localparam int DEPTH = 1 << PDU_AWIDTH;
    localparam logic [PDU_AWIDTH:0] DEPTH_CNT = DEPTH[PDU_AWIDTH:0];
    localparam logic [PDU_AWIDTH:0] MAX_CNT   = MAX_PDU_FLITS[PDU_AWIDTH:0];

    logic [PDU_AWIDTH-1:0] tail;
    logic [PDU_AWIDTH-1:0] head;
    logic                  commit_r;
    logic [PDU_AWIDTH-1:0] commit_size_r;
    logic                  pop;
    logic [PDU_AWIDTH:0]   add_cnt;
    logic [PDU_AWIDTH:0]   sub_cnt;
    logic [PDU_AWIDTH:0]   free_cnt;

    assign base_addr = tail;

    // pops on an empty ring are dropped
    assign pop         = rd_en && (occupancy != '0);
    assign rd_en_mem   = pop;
    assign rd_addr_mem = head;

    assign free_cnt    = DEPTH_CNT - occupancy;
    assign almost_full = (free_cnt < MAX_CNT);

    // occupancy only counts a PDU once its header has landed
    assign add_cnt = commit_r ? {1'b0, commit_size_r} : '0;
    assign sub_cnt = {{PDU_AWIDTH{1'b0}}, pop};

    always_ff @(posedge clk) begin
        if (rst) begin
            tail            <= '0;
            head            <= '0;
            commit_r        <= 1'b0;
            commit_size_r   <= '0;
            base_addr_valid <= 1'b0;
            rd_valid        <= 1'b0;
            occupancy       <= '0;
        end else begin
            commit_r        <= update_valid;
            commit_size_r   <= update_size;
            base_addr_valid <= commit_r;
            rd_valid        <= pop;

            if (update_valid) begin
                tail <= tail + update_size;
            end

            if (pop) begin
                head <= head + 1'b1;
            end

            occupancy <= occupancy + add_cnt - sub_cnt;
        end
    end

endmodule

/* hw/pdu_gen.sv */
`timescale 1ns/1ps

module pdu_gen #(
    parameter int PDU_AWIDTH = 6
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               in_sop,
    input  logic                               in_eop,
    input  logic [pdu_pkg::FLIT_WIDTH-1:0]     in_data,
    input  logic [pdu_pkg::EMPTY_WIDTH-1:0]    in_empty,
    input  logic                               in_valid,
    output logic                               in_ready,
    input  logic                               in_meta_valid,
    input  pdu_pkg::metadata_t                 in_meta_data,
    output logic                               in_meta_ready,
    output pdu_pkg::flit_lite_t                wr_data,
    output logic [PDU_AWIDTH-1:0]              wr_addr,
    output logic                               wr_en,
    input  logic [PDU_AWIDTH-1:0]              base_addr,
    input  logic                               base_addr_valid,
    input  logic                               almost_full,
    output logic                               update_valid,
    output logic [PDU_AWIDTH-1:0]              update_size
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_WRITE_HDR,
        ST_WAIT
    } state_t;

    state_t state;

    // pipeline stage ahead of the output register
    logic                             pdu_wren_r;
    logic [pdu_pkg::FLIT_WIDTH-1:0]   pdu_data_r;
    logic                             pdu_sop_r;
    logic                             pdu_eop_r;
    logic                             swap_r;
    logic [PDU_AWIDTH-1:0]            pdu_addr_r;

    logic [pdu_pkg::FLIT_WIDTH-1:0]   data_swap;
    logic [pdu_pkg::PSIZE_WIDTH-1:0]  flit_bytes;
    logic [pdu_pkg::PSIZE_WIDTH-1:0]  pdu_size;
    logic [pdu_pkg::PFLIT_WIDTH-1:0]  pdu_flit;
    logic [pdu_pkg::PDUID_WIDTH-1:0]  pdu_id;
    logic                             first_flit;
    pdu_pkg::pdu_hdr_t                pdu_hdr;

    assign in_ready   = (state == ST_WRITE);
    assign first_flit = (pdu_flit == '0);

    // last flit only counts its valid bytes
    assign flit_bytes = in_eop
        ? pdu_pkg::PSIZE_WIDTH'(pdu_pkg::FLIT_BYTES) - pdu_pkg::PSIZE_WIDTH'(in_empty)
        : pdu_pkg::PSIZE_WIDTH'(pdu_pkg::FLIT_BYTES);

    always_comb begin
        pdu_hdr          = '0;
        pdu_hdr.queue_id = in_meta_data.queue_id;
        pdu_hdr.action   = '0;
        pdu_hdr.pdu_flit = pdu_flit;
        pdu_hdr.pdu_size = pdu_size;
        pdu_hdr.prot     = in_meta_data.prot;
        pdu_hdr.tuple    = in_meta_data.tuple;
        pdu_hdr.pdu_id   = pdu_id;
    end

    // byte order reversal across the whole flit
    for (genvar i = 0; i < pdu_pkg::FLIT_BYTES; i++) begin : g_swap
        assign data_swap[i*8 +: 8] = pdu_data_r[(pdu_pkg::FLIT_BYTES-1-i)*8 +: 8];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_IDLE;
            in_meta_ready <= 1'b0;
            update_valid  <= 1'b0;
            update_size   <= '0;
            pdu_wren_r    <= 1'b0;
            wr_en         <= 1'b0;
            pdu_size      <= '0;
            pdu_flit      <= '0;
            pdu_id        <= '0;
        end else begin
            in_meta_ready <= 1'b0;
            update_valid  <= 1'b0;
            pdu_wren_r    <= 1'b0;
            wr_en         <= pdu_wren_r;

            case (state)
                ST_IDLE: begin
                    pdu_size <= '0;
                    pdu_flit <= '0;
                    if (in_meta_valid && !in_meta_ready && !almost_full) begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (in_valid) begin
                        pdu_wren_r <= 1'b1;
                        pdu_flit   <= pdu_flit + 1'b1;
                        pdu_size   <= pdu_size + flit_bytes;
                        if (in_eop) begin
                            state <= ST_WRITE_HDR;
                        end
                    end
                end
                ST_WRITE_HDR: begin
                    pdu_wren_r    <= 1'b1;
                    in_meta_ready <= 1'b1;
                    update_valid  <= 1'b1;
                    // header plus payload
                    update_size   <= pdu_flit[PDU_AWIDTH-1:0] + 1'b1;
                    pdu_id        <= pdu_id + 1'b1;
                    state         <= ST_WAIT;
                end
                ST_WAIT: begin
                    // controller has moved the tail
                    if (base_addr_valid) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_WRITE && in_valid) begin
            pdu_data_r <= in_data;
            swap_r     <= 1'b1;
            pdu_sop_r  <= 1'b0;
            pdu_eop_r  <= in_eop;
            // slot at base_addr is kept for the header
            if (first_flit) begin
                pdu_addr_r <= base_addr + 1'b1;
            end else begin
                pdu_addr_r <= pdu_addr_r + 1'b1;
            end
        end else if (state == ST_WRITE_HDR) begin
            pdu_data_r <= pdu_hdr;
            swap_r     <= 1'b0;
            pdu_sop_r  <= 1'b1;
            pdu_eop_r  <= 1'b0;
            pdu_addr_r <= base_addr;
        end
    end

    // output register
    always_ff @(posedge clk) begin
        wr_data.data <= swap_r ? data_swap : pdu_data_r;
        wr_data.sop  <= pdu_sop_r;
        wr_data.eop  <= pdu_eop_r;
        wr_addr      <= pdu_addr_r;
    end

endmodule

/* hw/pdu_ring_top.sv */
`timescale 1ns/1ps

module pdu_ring_top #(
    parameter int PDU_AWIDTH    = 6,
    parameter int MAX_PDU_FLITS = 9
) (
    input  logic                             clk,
    input  logic                             rst,
    // packet stream
    input  logic [pdu_pkg::FLIT_WIDTH-1:0]   in_data,
    input  logic                             in_sop,
    input  logic                             in_eop,
    input  logic [pdu_pkg::EMPTY_WIDTH-1:0]  in_empty,
    input  logic                             in_valid,
    output logic                             in_ready,
    // per packet metadata
    input  logic                             in_meta_valid,
    input  pdu_pkg::metadata_t               in_meta_data,
    output logic                             in_meta_ready,
    // reader side
    input  logic                             rd_en,
    output logic                             rd_valid,
    output pdu_pkg::flit_lite_t              rd_data,
    output logic [PDU_AWIDTH:0]              occupancy
);

    pdu_pkg::flit_lite_t    wr_data;
    logic [PDU_AWIDTH-1:0]  wr_addr;
    logic                   wr_en;
    logic [PDU_AWIDTH-1:0]  base_addr;
    logic                   base_addr_valid;
    logic                   almost_full;
    logic                   update_valid;
    logic [PDU_AWIDTH-1:0]  update_size;
    logic [PDU_AWIDTH-1:0]  rd_addr_mem;
    logic                   rd_en_mem;

    pdu_gen #(
        .PDU_AWIDTH(PDU_AWIDTH)
    ) u_pdu_gen (
        .clk            (clk),
        .rst            (rst),
        .in_sop         (in_sop),
        .in_eop         (in_eop),
        .in_data        (in_data),
        .in_empty       (in_empty),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_meta_valid  (in_meta_valid),
        .in_meta_data   (in_meta_data),
        .in_meta_ready  (in_meta_ready),
        .wr_data        (wr_data),
        .wr_addr        (wr_addr),
        .wr_en          (wr_en),
        .base_addr      (base_addr),
        .base_addr_valid(base_addr_valid),
        .almost_full    (almost_full),
        .update_valid   (update_valid),
        .update_size    (update_size)
    );

    rb_ctrl #(
        .PDU_AWIDTH   (PDU_AWIDTH),
        .MAX_PDU_FLITS(MAX_PDU_FLITS)
    ) u_rb_ctrl (
        .clk            (clk),
        .rst            (rst),
        .update_valid   (update_valid),
        .update_size    (update_size),
        .rd_en          (rd_en),
        .base_addr      (base_addr),
        .base_addr_valid(base_addr_valid),
        .almost_full    (almost_full),
        .rd_addr_mem    (rd_addr_mem),
        .rd_en_mem      (rd_en_mem),
        .rd_valid       (rd_valid),
        .occupancy      (occupancy)
    );

    rb_mem #(
        .PDU_AWIDTH(PDU_AWIDTH)
    ) u_rb_mem (
        .clk    (clk),
        .wr_en  (wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_en  (rd_en_mem),
        .rd_addr(rd_addr_mem),
        .rd_flit(rd_data)
    );

endmodule

/* verif/pdu_ring_tb.sv */
`timescale 1ns/1ps

module pdu_ring_tb;

    localparam int AW            = 6;
    localparam int MAX_PDU_FLITS = 9;
    localparam int RING_DEPTH    = 1 << AW;
    localparam int CW            = pdu_pkg::FLIT_WIDTH + 2;
    localparam int MAX_PAYLOAD   = MAX_PDU_FLITS - 1;
    localparam int NUM_PKTS      = 14;
    localparam int STALL_CYCLES  = 50;

    logic                            clk = 1'b0;
    logic                            rst;
    logic [pdu_pkg::FLIT_WIDTH-1:0]  in_data;
    logic                            in_sop;
    logic                            in_eop;
    logic [pdu_pkg::EMPTY_WIDTH-1:0] in_empty;
    logic                            in_valid;
    logic                            in_ready;
    logic                            in_meta_valid;
    pdu_pkg::metadata_t              in_meta_data;
    logic                            in_meta_ready;
    logic                            rd_en;
    logic                            rd_valid;
    pdu_pkg::flit_lite_t             rd_data;
    logic [AW:0]                     occupancy;

    // stimulus table, one row per packet
    int                              tbl_flits [NUM_PKTS];
    logic [pdu_pkg::EMPTY_WIDTH-1:0] tbl_empty [NUM_PKTS];
    pdu_pkg::metadata_t              tbl_meta  [NUM_PKTS];
    bit                              tbl_drain [NUM_PKTS];
    logic [pdu_pkg::FLIT_WIDTH-1:0]  payload_mem [NUM_PKTS*MAX_PAYLOAD];

    // expected ring contents in read order
    pdu_pkg::flit_lite_t exp_q[$];
    string               name_q[$];

    int row_cnt     = 0;
    int total_flits = 0;
    int seed;
    int cycle_cnt   = 0;
    int cycle_limit = 200;
    int meta_pulses = 0;
    int stalls      = 0;
    int i;
    bit stalled;

    pdu_ring_top #(
        .PDU_AWIDTH   (AW),
        .MAX_PDU_FLITS(MAX_PDU_FLITS)
    ) dut (
        .clk          (clk),
        .rst          (rst),
        .in_data      (in_data),
        .in_sop       (in_sop),
        .in_eop       (in_eop),
        .in_empty     (in_empty),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_meta_valid(in_meta_valid),
        .in_meta_data (in_meta_data),
        .in_meta_ready(in_meta_ready),
        .rd_en        (rd_en),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data),
        .occupancy    (occupancy)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (!rst && in_meta_ready) begin
            meta_pulses <= meta_pulses + 1;
        end
        if (int'(occupancy) > RING_DEPTH) begin
            report_failure("occupancy went past the ring depth");
        end
        if (cycle_cnt >= cycle_limit) begin
            report_failure($sformatf("timeout: run still busy after %0d cycles", cycle_limit));
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [CW-1:0] expected,
                               input logic [CW-1:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("Error %s: expected %0h, actual %0h",
                                     name, expected, actual));
        end
    endtask

    task automatic add_row(input int n, input logic [5:0] empty, input logic [31:0] qid,
                           input logic [31:0] prot, input logic [31:0] sip,
                           input logic [31:0] dip, input logic [15:0] sport,
                           input logic [15:0] dport, input bit drain);
        int f;
        int w;
        tbl_flits[row_cnt]               = n;
        tbl_empty[row_cnt]               = empty;
        tbl_drain[row_cnt]               = drain;
        tbl_meta[row_cnt].queue_id       = qid;
        tbl_meta[row_cnt].prot           = prot;
        tbl_meta[row_cnt].tuple.src_ip   = sip;
        tbl_meta[row_cnt].tuple.dst_ip   = dip;
        tbl_meta[row_cnt].tuple.src_port = sport;
        tbl_meta[row_cnt].tuple.dst_port = dport;
        for (f = 0; f < n; f++) begin
            for (w = 0; w < pdu_pkg::FLIT_WIDTH / 32; w++) begin
                payload_mem[row_cnt*MAX_PAYLOAD + f][w*32 +: 32] = $random(seed);
            end
        end
        total_flits = total_flits + n;
        row_cnt     = row_cnt + 1;
    endtask

    // byte 0 of the input ends up as the top byte
    function automatic logic [pdu_pkg::FLIT_WIDTH-1:0] reverse_bytes(
            input logic [pdu_pkg::FLIT_WIDTH-1:0] d);
        logic [pdu_pkg::FLIT_WIDTH-1:0] r;
        int b;
        for (b = 0; b < pdu_pkg::FLIT_BYTES; b++) begin
            r[pdu_pkg::FLIT_WIDTH-1-8*b -: 8] = d[8*b +: 8];
        end
        return r;
    endfunction

    // generator stays idle while fewer than MAX_PDU_FLITS entries are free
    function automatic int count_expected_stalls();
        int occ;
        int cnt;
        int k;
        occ = 0;
        cnt = 0;
        for (k = 0; k < row_cnt; k++) begin
            if (RING_DEPTH - occ < MAX_PDU_FLITS) begin
                cnt = cnt + 1;
                occ = 0;
            end
            occ = occ + tbl_flits[k] + 1;
            if (tbl_drain[k]) begin
                occ = 0;
            end
        end
        return cnt;
    endfunction

    task automatic queue_expected(input int idx);
        pdu_pkg::pdu_hdr_t   hdr;
        pdu_pkg::flit_lite_t e;
        int                  n;
        int                  f;
        n            = tbl_flits[idx];
        hdr          = '0;
        hdr.queue_id = tbl_meta[idx].queue_id;
        hdr.pdu_flit = 16'(n);
        hdr.pdu_size = 16'(n * pdu_pkg::FLIT_BYTES - int'(tbl_empty[idx]));
        hdr.prot     = tbl_meta[idx].prot;
        hdr.tuple    = tbl_meta[idx].tuple;
        hdr.pdu_id   = 32'(idx);
        e.data       = hdr;
        e.sop        = 1'b1;
        e.eop        = 1'b0;
        exp_q.push_back(e);
        name_q.push_back($sformatf("pdu %0d header", idx));
        for (f = 0; f < n; f++) begin
            e.data = reverse_bytes(payload_mem[idx*MAX_PAYLOAD + f]);
            e.sop  = 1'b0;
            e.eop  = (f == n - 1);
            exp_q.push_back(e);
            name_q.push_back($sformatf("pdu %0d flit %0d", idx, f));
        end
    endtask

    task automatic send_packet(input int idx, output bit blocked);
        int n;
        int f;
        int waited;
        int occ_before;
        int pulses_before;
        n             = tbl_flits[idx];
        blocked       = 1'b0;
        occ_before    = int'(occupancy);
        pulses_before = meta_pulses;
        in_meta_valid <= 1'b1;
        in_meta_data  <= tbl_meta[idx];
        f = 0;
        while (f < n && !blocked) begin
            in_data  <= payload_mem[idx*MAX_PAYLOAD + f];
            in_sop   <= (f == 0);
            in_eop   <= (f == n - 1);
            in_empty <= (f == n - 1) ? tbl_empty[idx] : '0;
            in_valid <= 1'b1;
            waited = 0;
            @(posedge clk);
            while (!in_ready && !blocked) begin
                waited = waited + 1;
                if (waited >= STALL_CYCLES) begin
                    blocked = 1'b1;
                end else begin
                    @(posedge clk);
                end
            end
            if (blocked && f != 0) begin
                report_failure($sformatf("packet %0d stalled in the middle of its flits", idx));
            end
            f = f + 1;
        end
        in_valid <= 1'b0;
        if (blocked) begin
            // metadata withdrawn so the generator stays idle during the drain
            in_meta_valid <= 1'b0;
        end else begin
            while (!in_meta_ready) begin
                @(posedge clk);
            end
            in_meta_valid <= 1'b0;
            queue_expected(idx);
            while (int'(occupancy) == occ_before) begin
                @(posedge clk);
            end
            check_value($sformatf("pdu %0d occupancy", idx), CW'(occ_before + n + 1),
                        CW'(int'(occupancy)));
            check_value($sformatf("pdu %0d meta_ready pulses", idx), CW'(1),
                        CW'(meta_pulses - pulses_before));
        end
    endtask

    task automatic pop_and_check();
        pdu_pkg::flit_lite_t exp_e;
        pdu_pkg::pdu_hdr_t   exp_hdr;
        pdu_pkg::pdu_hdr_t   act_hdr;
        string               nm;
        rd_en <= 1'b1;
        @(posedge clk);
        rd_en <= 1'b0;
        @(posedge clk);
        while (!rd_valid) begin
            @(posedge clk);
        end
        if (exp_q.size() == 0) begin
            report_failure("ring returned a flit that no packet produced");
        end
        exp_e = exp_q.pop_front();
        nm    = name_q.pop_front();
        check_value({nm, " sop"}, CW'(exp_e.sop), CW'(rd_data.sop));
        check_value({nm, " eop"}, CW'(exp_e.eop), CW'(rd_data.eop));
        if (exp_e.sop) begin
            exp_hdr = exp_e.data;
            act_hdr = rd_data.data;
            check_value({nm, " pdu_id"}, CW'(exp_hdr.pdu_id), CW'(act_hdr.pdu_id));
            check_value({nm, " queue_id"}, CW'(exp_hdr.queue_id), CW'(act_hdr.queue_id));
            check_value({nm, " action"}, CW'(exp_hdr.action), CW'(act_hdr.action));
            check_value({nm, " pdu_flit"}, CW'(exp_hdr.pdu_flit), CW'(act_hdr.pdu_flit));
            check_value({nm, " pdu_size"}, CW'(exp_hdr.pdu_size), CW'(act_hdr.pdu_size));
            check_value({nm, " prot"}, CW'(exp_hdr.prot), CW'(act_hdr.prot));
            check_value({nm, " tuple"}, CW'(exp_hdr.tuple), CW'(act_hdr.tuple));
        end
        check_value({nm, " data"}, CW'(exp_e.data), CW'(rd_data.data));
    endtask

    task automatic drain_ring();
        while (occupancy != '0) begin
            pop_and_check();
        end
        check_value("entries left in model after drain", CW'(0), CW'(exp_q.size()));
    endtask

    initial begin
        seed          = 32'h22a4;
        rst           <= 1'b1;
        in_data       <= '0;
        in_sop        <= 1'b0;
        in_eop        <= 1'b0;
        in_empty      <= '0;
        in_valid      <= 1'b0;
        in_meta_valid <= 1'b0;
        in_meta_data  <= '0;
        rd_en         <= 1'b0;

        // flits, empty, queue_id, prot, src_ip, dst_ip, src_port, dst_port, drain after
        add_row(1, 6'd5,  32'h10, 32'h06, 32'h0a000001, 32'h0a000002, 16'd1024, 16'd80, 1);
        add_row(3, 6'd0,  32'h11, 32'h11, 32'h0a000003, 32'h0a000004, 16'd2048, 16'd53, 1);
        add_row(2, 6'd63, 32'h12, 32'h06, 32'hc0a80001, 32'hc0a80002, 16'd4000, 16'd22, 1);
        add_row(5, 6'd17, 32'h13, 32'h84, 32'hac100001, 32'hac100002, 16'd5001, 16'd443, 1);
        // no pops until the ring fills up
        add_row(8, 6'd1,  32'h20, 32'h06, 32'h0a010101, 32'h0a020202, 16'd6000, 16'd8080, 0);
        add_row(8, 6'd9,  32'h21, 32'h11, 32'h0a010102, 32'h0a020203, 16'd6001, 16'd8081, 0);
        add_row(8, 6'd32, 32'h22, 32'h06, 32'h0a010103, 32'h0a020204, 16'd6002, 16'd8082, 0);
        add_row(8, 6'd0,  32'h23, 32'h06, 32'h0a010104, 32'h0a020205, 16'd6003, 16'd8083, 0);
        add_row(8, 6'd40, 32'h24, 32'h11, 32'h0a010105, 32'h0a020206, 16'd6004, 16'd8084, 0);
        add_row(8, 6'd7,  32'h25, 32'h06, 32'h0a010106, 32'h0a020207, 16'd6005, 16'd8085, 0);
        add_row(8, 6'd60, 32'h26, 32'h84, 32'h0a010107, 32'h0a020208, 16'd6006, 16'd8086, 0);
        add_row(8, 6'd3,  32'h27, 32'h06, 32'h0a010108, 32'h0a020209, 16'd6007, 16'd8087, 0);
        add_row(4, 6'd12, 32'h28, 32'h11, 32'h0a010109, 32'h0a02020a, 16'd6008, 16'd8088, 0);
        add_row(6, 6'd50, 32'h29, 32'h06, 32'h0a01010a, 32'h0a02020b, 16'd6009, 16'd8089, 1);
        cycle_limit = 200 + 40 * total_flits;

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("reset in_ready", CW'(0), CW'(in_ready));
        check_value("reset in_meta_ready", CW'(0), CW'(in_meta_ready));
        check_value("reset rd_valid", CW'(0), CW'(rd_valid));
        check_value("reset occupancy", CW'(0), CW'(int'(occupancy)));

        for (i = 0; i < row_cnt; i++) begin
            send_packet(i, stalled);
            if (stalled) begin
                stalls = stalls + 1;
                check_value($sformatf("pdu %0d occupancy at stall", i), CW'(exp_q.size()),
                            CW'(int'(occupancy)));
                if (RING_DEPTH - exp_q.size() >= MAX_PDU_FLITS) begin
                    report_failure("input stalled although a whole PDU still fits");
                end
                drain_ring();
                send_packet(i, stalled);
                if (stalled) begin
                    report_failure("packet still blocked after the ring was drained");
                end
            end
            if (tbl_drain[i]) begin
                drain_ring();
            end
        end

        check_value("back-pressure stalls", CW'(count_expected_stalls()), CW'(stalls));
        check_value("total meta_ready pulses", CW'(row_cnt), CW'(meta_pulses));
        $display("No errors");
        $finish;
    end

endmodule

/* verilog.f */
hw/pdu_pkg.sv
hw/rb_mem.sv
hw/rb_ctrl.sv
hw/pdu_gen.sv
hw/pdu_ring_top.sv
verif/pdu_ring_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -j 0 --top-module pdu_ring_tb -f verilog.f -o Vpdu_ring_tb

./obj_dir/Vpdu_ring_tb | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "No errors" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation PASSED"
